//--- rtl/bus_pkg.sv
package bus_pkg;

	// byte address on the lite bus
	typedef logic [31:0] addr_t;

	// one data word
	typedef logic [31:0] word_t;

	// one strobe bit per byte lane of word_t
	typedef logic [3:0] strb_t;

	// response code on r and b channels
	typedef logic [1:0] resp_t;

	// standard response encodings
	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

endpackage

//--- rtl/soc_pkg.sv
package soc_pkg;

	// main memory window
	localparam bus_pkg::addr_t MEM_BASE = 32'h8000_0000;
	localparam int MEM_WORDS = 1024;

	// uart data register window, write only
	localparam bus_pkg::addr_t UART_BASE = 32'ha000_03f8;
	localparam int UART_SPAN = 8;

	// clocks per serial bit
	localparam int BAUD_DIV = 8;

	// one serial character
	typedef logic [7:0] byte_t;

	// crossbar states, one transaction at a time
	typedef enum logic [2:0] {
		IDLE,
		RD_MEM,
		RD_ERR,
		WR_MEM,
		WR_UART,
		WR_ERR
	} xbar_state_t;

endpackage

//--- rtl/lite_if.sv
`timescale 1ns/1ps

// read address and read data channels
interface lite_rd_if;
	bus_pkg::addr_t araddr;
	logic arvalid;
	logic arready;

	bus_pkg::word_t rdata;
	bus_pkg::resp_t rresp;
	logic rvalid;
	logic rready;

	modport mst (
		output araddr, arvalid, rready,
		input arready, rdata, rresp, rvalid
	);

	modport slv (
		input araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid
	);
endinterface

// write address, write data and write response channels
interface lite_wr_if;
	bus_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;

	bus_pkg::word_t wdata;
	bus_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;

	bus_pkg::resp_t bresp;
	logic bvalid;
	logic bready;

	modport mst (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input awready, wready, bresp, bvalid
	);

	modport slv (
		input awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output awready, wready, bresp, bvalid
	);
endinterface

//--- rtl/bus_xbar.sv
`timescale 1ns/1ps

module bus_xbar (
	input logic clk,
	input logic rst,
	lite_rd_if.slv up_rd,
	lite_wr_if.slv up_wr,
	lite_rd_if.mst mem_rd,
	lite_wr_if.mst mem_wr,
	lite_wr_if.mst uart_wr
);

	soc_pkg::xbar_state_t state;
	soc_pkg::xbar_state_t state_nxt;

	// error response phase, address side already taken
	logic err_pend;
	bus_pkg::resp_t err_code;

	function automatic logic in_mem(input bus_pkg::addr_t addr);
		bus_pkg::addr_t off;
		off = addr - soc_pkg::MEM_BASE;
		return addr >= soc_pkg::MEM_BASE && off < bus_pkg::addr_t'(soc_pkg::MEM_WORDS * 4);
	endfunction

	function automatic logic in_uart(input bus_pkg::addr_t addr);
		bus_pkg::addr_t off;
		off = addr - soc_pkg::UART_BASE;
		return addr >= soc_pkg::UART_BASE && off < bus_pkg::addr_t'(soc_pkg::UART_SPAN);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= soc_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// read errors keep their code until the r handshake
	always_ff @(posedge clk) begin
		if (state == soc_pkg::IDLE && up_rd.arvalid) begin
			err_code <= in_uart(up_rd.araddr) ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_DECERR;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			err_pend <= 1'b0;
		end else if (state_nxt == soc_pkg::IDLE) begin
			err_pend <= 1'b0;
		end else if (state == soc_pkg::RD_ERR && up_rd.arvalid) begin
			err_pend <= 1'b1;
		end else if (state == soc_pkg::WR_ERR && up_wr.awvalid && up_wr.wvalid) begin
			err_pend <= 1'b1;
		end
	end

	// next state; read wins when both arrive together
	always_comb begin
		state_nxt = state;
		case (state)
			soc_pkg::IDLE: begin
				if (up_rd.arvalid) begin
					if (in_mem(up_rd.araddr)) begin
						state_nxt = soc_pkg::RD_MEM;
					end else begin
						state_nxt = soc_pkg::RD_ERR;
					end
				end else if (up_wr.awvalid) begin
					if (in_mem(up_wr.awaddr)) begin
						state_nxt = soc_pkg::WR_MEM;
					end else if (in_uart(up_wr.awaddr)) begin
						state_nxt = soc_pkg::WR_UART;
					end else begin
						state_nxt = soc_pkg::WR_ERR;
					end
				end
			end
			soc_pkg::RD_MEM: begin
				if (mem_rd.rvalid && up_rd.rready) begin
					state_nxt = soc_pkg::IDLE;
				end
			end
			soc_pkg::RD_ERR, soc_pkg::WR_ERR: begin
				if (err_pend && ((state == soc_pkg::RD_ERR) ? up_rd.rready : up_wr.bready)) begin
					state_nxt = soc_pkg::IDLE;
				end
			end
			soc_pkg::WR_MEM: begin
				if (mem_wr.bvalid && up_wr.bready) begin
					state_nxt = soc_pkg::IDLE;
				end
			end
			soc_pkg::WR_UART: begin
				if (uart_wr.bvalid && up_wr.bready) begin
					state_nxt = soc_pkg::IDLE;
				end
			end
			default: begin
				state_nxt = soc_pkg::IDLE;
			end
		endcase
	end

	// channel routing; everything not routed stays quiet
	always_comb begin
		up_rd.arready = 1'b0;
		up_rd.rdata = '0;
		up_rd.rresp = bus_pkg::RESP_OKAY;
		up_rd.rvalid = 1'b0;
		up_wr.awready = 1'b0;
		up_wr.wready = 1'b0;
		up_wr.bresp = bus_pkg::RESP_OKAY;
		up_wr.bvalid = 1'b0;

		mem_rd.araddr = '0;
		mem_rd.arvalid = 1'b0;
		mem_rd.rready = 1'b0;
		mem_wr.awaddr = '0;
		mem_wr.awvalid = 1'b0;
		mem_wr.wdata = '0;
		mem_wr.wstrb = '0;
		mem_wr.wvalid = 1'b0;
		mem_wr.bready = 1'b0;

		uart_wr.awaddr = '0;
		uart_wr.awvalid = 1'b0;
		uart_wr.wdata = '0;
		uart_wr.wstrb = '0;
		uart_wr.wvalid = 1'b0;
		uart_wr.bready = 1'b0;

		case (state)
			soc_pkg::RD_MEM: begin
				mem_rd.araddr = up_rd.araddr;
				mem_rd.arvalid = up_rd.arvalid;
				up_rd.arready = mem_rd.arready;
				up_rd.rdata = mem_rd.rdata;
				up_rd.rresp = mem_rd.rresp;
				up_rd.rvalid = mem_rd.rvalid;
				mem_rd.rready = up_rd.rready;
			end
			soc_pkg::WR_MEM: begin
				mem_wr.awaddr = up_wr.awaddr;
				mem_wr.awvalid = up_wr.awvalid;
				up_wr.awready = mem_wr.awready;
				mem_wr.wdata = up_wr.wdata;
				mem_wr.wstrb = up_wr.wstrb;
				mem_wr.wvalid = up_wr.wvalid;
				up_wr.wready = mem_wr.wready;
				up_wr.bresp = mem_wr.bresp;
				up_wr.bvalid = mem_wr.bvalid;
				mem_wr.bready = up_wr.bready;
			end
			soc_pkg::WR_UART: begin
				uart_wr.awaddr = up_wr.awaddr;
				uart_wr.awvalid = up_wr.awvalid;
				up_wr.awready = uart_wr.awready;
				uart_wr.wdata = up_wr.wdata;
				uart_wr.wstrb = up_wr.wstrb;
				uart_wr.wvalid = up_wr.wvalid;
				up_wr.wready = uart_wr.wready;
				up_wr.bresp = uart_wr.bresp;
				up_wr.bvalid = uart_wr.bvalid;
				uart_wr.bready = up_wr.bready;
			end
			soc_pkg::RD_ERR: begin
				// xbar answers as the slave
				up_rd.arready = !err_pend;
				up_rd.rvalid = err_pend;
				up_rd.rresp = err_code;
			end
			soc_pkg::WR_ERR: begin
				up_wr.awready = !err_pend;
				up_wr.wready = !err_pend;
				up_wr.bvalid = err_pend;
				up_wr.bresp = bus_pkg::RESP_DECERR;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- rtl/mem_slave.sv
`timescale 1ns/1ps

module mem_slave (
	input logic clk,
	input logic rst,
	lite_rd_if.slv rd,
	lite_wr_if.slv wr
);

	typedef logic [$clog2(soc_pkg::MEM_WORDS)-1:0] idx_t;

	bus_pkg::word_t mem [soc_pkg::MEM_WORDS];

	idx_t rd_idx;
	idx_t wr_idx;
	logic ar_rdy;
	logic r_vld;
	bus_pkg::word_t rdata_q;
	logic b_vld;
	logic wr_acc;

	// word index; range check is done upstream
	assign rd_idx = rd.araddr[$bits(idx_t)+1:2];
	assign wr_idx = wr.awaddr[$bits(idx_t)+1:2];

	assign rd.arready = ar_rdy;
	assign rd.rvalid = r_vld;
	assign rd.rdata = rdata_q;
	assign rd.rresp = bus_pkg::RESP_OKAY;

	// aw and w taken in the same cycle
	assign wr_acc = wr.awvalid && wr.wvalid && !b_vld;
	assign wr.awready = wr_acc;
	assign wr.wready = wr_acc;
	assign wr.bvalid = b_vld;
	assign wr.bresp = bus_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			ar_rdy <= 1'b0;
			r_vld <= 1'b0;
		end else begin
			if (rd.arvalid && ar_rdy) begin
				ar_rdy <= 1'b0;
				r_vld <= 1'b1;
			end else if (rd.arvalid && !r_vld) begin
				ar_rdy <= 1'b1;
			end
			if (r_vld && rd.rready) begin
				r_vld <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd.arvalid && ar_rdy) begin
			rdata_q <= mem[rd_idx];
		end
	end

	// byte lanes follow the strobes
	always_ff @(posedge clk) begin
		if (wr_acc) begin
			for (int i = 0; i < $bits(bus_pkg::strb_t); i++) begin
				if (wr.wstrb[i]) begin
					mem[wr_idx][i*8 +: 8] <= wr.wdata[i*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			b_vld <= 1'b0;
		end else if (wr_acc) begin
			b_vld <= 1'b1;
		end else if (wr.bready) begin
			b_vld <= 1'b0;
		end
	end

endmodule

//--- rtl/uart_tx_slave.sv
`timescale 1ns/1ps

module uart_tx_slave (
	input logic clk,
	input logic rst,
	lite_wr_if.slv wr,
	output logic tx
);

	localparam int FRAME_BITS = 10;

	soc_pkg::byte_t tx_byte;
	logic [FRAME_BITS-1:0] shreg;
	logic [$clog2(soc_pkg::BAUD_DIV)-1:0] baud_cnt;
	logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
	logic busy;
	logic b_pend;
	logic wr_acc;

	// offset inside the uart window is ignored
	assign tx_byte = wr.wdata[7:0];

	// no new write until frame done and response taken
	assign wr_acc = wr.awvalid && wr.wvalid && !busy && !b_pend;
	assign wr.awready = wr_acc;
	assign wr.wready = wr_acc;
	assign wr.bvalid = b_pend;
	assign wr.bresp = bus_pkg::RESP_OKAY;

	// line idles high since the register refills with ones
	assign tx = shreg[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			shreg <= '1;
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (wr_acc) begin
			// stop, data lsb first, start
			shreg <= {1'b1, tx_byte, 1'b0};
			busy <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (baud_cnt == $bits(baud_cnt)'(soc_pkg::BAUD_DIV - 1)) begin
				baud_cnt <= '0;
				shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
				if (bit_cnt == $bits(bit_cnt)'(FRAME_BITS - 1)) begin
					busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// write response, raised the cycle after acceptance
	always_ff @(posedge clk) begin
		if (rst) begin
			b_pend <= 1'b0;
		end else if (wr_acc) begin
			b_pend <= 1'b1;
		end else if (wr.bready) begin
			b_pend <= 1'b0;
		end
	end

endmodule

//--- rtl/lite_soc.sv
`timescale 1ns/1ps

module lite_soc (
	input logic clk,
	input logic rst,
	input bus_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output bus_pkg::word_t rdata,
	output bus_pkg::resp_t rresp,
	output logic rvalid,
	input logic rready,
	input bus_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input bus_pkg::word_t wdata,
	input bus_pkg::strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output bus_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,
	output logic tx
);

	lite_rd_if up_rd ();
	lite_wr_if up_wr ();
	lite_rd_if mem_rd ();
	lite_wr_if mem_wr ();
	lite_wr_if uart_wr ();

	// host pins onto the upstream channels
	assign up_rd.araddr = araddr;
	assign up_rd.arvalid = arvalid;
	assign up_rd.rready = rready;
	assign arready = up_rd.arready;
	assign rdata = up_rd.rdata;
	assign rresp = up_rd.rresp;
	assign rvalid = up_rd.rvalid;

	assign up_wr.awaddr = awaddr;
	assign up_wr.awvalid = awvalid;
	assign up_wr.wdata = wdata;
	assign up_wr.wstrb = wstrb;
	assign up_wr.wvalid = wvalid;
	assign up_wr.bready = bready;
	assign awready = up_wr.awready;
	assign wready = up_wr.wready;
	assign bresp = up_wr.bresp;
	assign bvalid = up_wr.bvalid;

	bus_xbar xbar (
		.clk(clk),
		.rst(rst),
		.up_rd(up_rd.slv),
		.up_wr(up_wr.slv),
		.mem_rd(mem_rd.mst),
		.mem_wr(mem_wr.mst),
		.uart_wr(uart_wr.mst)
	);

	mem_slave mem (
		.clk(clk),
		.rst(rst),
		.rd(mem_rd.slv),
		.wr(mem_wr.slv)
	);

	uart_tx_slave uart (
		.clk(clk),
		.rst(rst),
		.wr(uart_wr.slv),
		.tx(tx)
	);

endmodule

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- test/soc_chk.sv
`timescale 1ns/1ps

module soc_chk (
	input logic clk,
	input logic rst,
	input logic arready,
	input logic awready,
	input bus_pkg::word_t rdata,
	input bus_pkg::resp_t rresp,
	input logic rvalid,
	input logic rready,
	input bus_pkg::resp_t bresp,
	input logic bvalid,
	input logic bready,
	input logic tx
);

	// cycles left in which a frame may still drive tx low
	int frame_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_cnt <= 0;
		end else if (frame_cnt != 0) begin
			frame_cnt <= frame_cnt - 1;
		end else if (!tx) begin
			frame_cnt <= 9 * soc_pkg::BAUD_DIV;
		end
	end

	r_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("r channel changed before rready");

	b_stable: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("b channel changed before bready");

	tx_idle_high: assert property (@(posedge clk) disable iff (rst)
		frame_cnt == 0 && !$fell(tx) |-> tx)
		else $error("tx low outside a frame");

	one_addr_ready: assert property (@(posedge clk) disable iff (rst)
		!(arready && awready))
		else $error("arready and awready high together");

endmodule

bind lite_soc soc_chk chk (
	.clk(clk),
	.rst(rst),
	.arready(arready),
	.awready(awready),
	.rdata(rdata),
	.rresp(rresp),
	.rvalid(rvalid),
	.rready(rready),
	.bresp(bresp),
	.bvalid(bvalid),
	.bready(bready),
	.tx(tx)
);

//--- test/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

	typedef bus_pkg::word_t model_t [soc_pkg::MEM_WORDS];

	// upper bound on operations issued below
	localparam int NUM_TESTS = 100;
	localparam int TIMEOUT_NS = NUM_TESTS * (20 + 10 * soc_pkg::BAUD_DIV) * 4 * 2;
	localparam int TEST_WORDS = 16;

	logic clk;
	logic rst;
	bus_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	bus_pkg::word_t rdata;
	bus_pkg::resp_t rresp;
	logic rvalid;
	logic rready;
	bus_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	bus_pkg::word_t wdata;
	bus_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;
	bus_pkg::resp_t bresp;
	logic bvalid;
	logic bready;
	logic tx;

	integer seed = 32'hc6056406;
	int pass_cnt = 0;
	int fail_cnt = 0;
	model_t shadow;

	// pending comparisons, filled by the stimulus and the tx monitor
	string word_name_q[$];
	bus_pkg::word_t word_exp_q[$];
	bus_pkg::word_t word_act_q[$];
	string resp_name_q[$];
	bus_pkg::resp_t resp_exp_q[$];
	bus_pkg::resp_t resp_act_q[$];
	string byte_name_q[$];
	soc_pkg::byte_t byte_exp_q[$];
	soc_pkg::byte_t rx_q[$];

	clk_gen clocks (
		.clk(clk),
		.rst(rst)
	);

	lite_soc UUT (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.tx(tx)
	);

	function automatic logic is_mem(input bus_pkg::addr_t addr);
		return addr >= soc_pkg::MEM_BASE && addr < soc_pkg::MEM_BASE + 32'h1000;
	endfunction

	function automatic logic is_uart(input bus_pkg::addr_t addr);
		return addr >= soc_pkg::UART_BASE && addr < soc_pkg::UART_BASE + 32'd8;
	endfunction

	// expected read data and response of one access
	function automatic bus_pkg::word_t expect_access(input logic is_write,
			input bus_pkg::addr_t addr, input model_t model, output bus_pkg::resp_t resp);
		if (is_mem(addr)) begin
			resp = bus_pkg::RESP_OKAY;
			return is_write ? '0 : model[addr[11:2]];
		end
		if (is_uart(addr)) begin
			resp = is_write ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
			return '0;
		end
		resp = bus_pkg::RESP_DECERR;
		return '0;
	endfunction

	task automatic apply_strobes(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
			input bus_pkg::strb_t strb);
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				shadow[addr[11:2]][i*8 +: 8] = data[i*8 +: 8];
			end
		end
	endtask

	task automatic check_word(input string name, input bus_pkg::word_t exp,
			input bus_pkg::word_t act);
		if (act === exp) begin
			pass_cnt++;
			$display("Pass %s", name);
		end else begin
			fail_cnt++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input bus_pkg::resp_t exp,
			input bus_pkg::resp_t act);
		if (act === exp) begin
			pass_cnt++;
			$display("Pass %s", name);
		end else begin
			fail_cnt++;
			$display("Fail %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input soc_pkg::byte_t exp,
			input soc_pkg::byte_t act);
		if (act === exp) begin
			pass_cnt++;
			$display("Pass %s", name);
		end else begin
			fail_cnt++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic do_read(input bus_pkg::addr_t addr, output bus_pkg::word_t data,
			output bus_pkg::resp_t resp);
		int delay;
		delay = $unsigned($random(seed)) % 6;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		// ready seen at a falling edge, handshake on the next rising edge
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		repeat (delay) @(negedge clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic do_write(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
			input bus_pkg::strb_t strb, output bus_pkg::resp_t resp,
			output time t_acc, output time t_resp);
		int delay;
		logic aw_done;
		logic w_done;
		delay = $unsigned($random(seed)) % 6;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (awvalid || wvalid) begin
			@(negedge clk);
			// handshakes seen one falling edge earlier are complete now
			if (aw_done) awvalid = 1'b0;
			if (w_done) wvalid = 1'b0;
			if (awvalid && awready) begin
				aw_done = 1'b1;
				t_acc = $time;
			end
			if (wvalid && wready) begin
				w_done = 1'b1;
				t_acc = $time;
			end
		end
		while (!bvalid) @(negedge clk);
		repeat (delay) @(negedge clk);
		resp = bresp;
		t_resp = $time;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	// one access, its expected results queued for comparison
	task automatic run_op(input logic is_write, input bus_pkg::addr_t addr,
			input bus_pkg::word_t data, input bus_pkg::strb_t strb, input string name,
			output time t_acc, output time t_resp);
		bus_pkg::word_t exp_data;
		bus_pkg::word_t act_data;
		bus_pkg::resp_t exp_resp;
		bus_pkg::resp_t act_resp;
		exp_data = expect_access(is_write, addr, shadow, exp_resp);
		if (is_write) begin
			do_write(addr, data, strb, act_resp, t_acc, t_resp);
			if (is_mem(addr)) apply_strobes(addr, data, strb);
			if (is_uart(addr)) begin
				byte_name_q.push_back({name, "_tx"});
				byte_exp_q.push_back(data[7:0]);
			end
		end else begin
			do_read(addr, act_data, act_resp);
			word_name_q.push_back({name, "_data"});
			word_exp_q.push_back(exp_data);
			word_act_q.push_back(act_data);
		end
		resp_name_q.push_back({name, "_resp"});
		resp_exp_q.push_back(exp_resp);
		resp_act_q.push_back(act_resp);
	endtask

	// tx monitor, mid-bit sampling after the falling start edge
	initial begin
		soc_pkg::byte_t rx;
		@(negedge rst);
		forever begin
			@(negedge tx);
			repeat (soc_pkg::BAUD_DIV / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (soc_pkg::BAUD_DIV) @(negedge clk);
				rx[i] = tx;
			end
			repeat (soc_pkg::BAUD_DIV) @(negedge clk);
			if (tx !== 1'b1) begin
				fail_cnt++;
				$display("uart frame ended without a stop bit");
			end
			rx_q.push_back(rx);
		end
	end

	// comparison process
	initial begin
		forever begin
			@(negedge clk);
			while (word_exp_q.size() > 0) begin
				check_word(word_name_q.pop_front(), word_exp_q.pop_front(),
					word_act_q.pop_front());
			end
			while (resp_exp_q.size() > 0) begin
				check_resp(resp_name_q.pop_front(), resp_exp_q.pop_front(),
					resp_act_q.pop_front());
			end
			while (byte_exp_q.size() > 0 && rx_q.size() > 0) begin
				check_byte(byte_name_q.pop_front(), byte_exp_q.pop_front(), rx_q.pop_front());
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("run hung, watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

	initial begin
		time t_acc;
		time t_resp;
		time t_first;
		bus_pkg::addr_t addr;
		bus_pkg::addr_t bad_addr [5];
		int kind;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		bad_addr[0] = 32'h0000_0000;
		bad_addr[1] = soc_pkg::MEM_BASE + 32'h1000;
		bad_addr[2] = soc_pkg::UART_BASE - 32'd4;
		bad_addr[3] = soc_pkg::UART_BASE + 32'd8;
		bad_addr[4] = 32'hffff_fffc;
		do @(negedge clk); while (rst);

		// memory fill, partial strobes, readback
		for (int i = 0; i < TEST_WORDS; i++) begin
			run_op(1'b1, soc_pkg::MEM_BASE + 32'(i * 4), 32'h1000_0000 + 32'(i * 32'h0101_0111),
				4'hf, $sformatf("mem_fill_%0d", i), t_acc, t_resp);
		end
		run_op(1'b1, soc_pkg::MEM_BASE + 32'h4, 32'haabb_ccdd, 4'h1, "mem_strb_1", t_acc, t_resp);
		run_op(1'b1, soc_pkg::MEM_BASE + 32'h8, 32'h1122_3344, 4'h6, "mem_strb_6", t_acc, t_resp);
		run_op(1'b1, soc_pkg::MEM_BASE + 32'hc, 32'h5566_7788, 4'h8, "mem_strb_8", t_acc, t_resp);
		run_op(1'b1, soc_pkg::MEM_BASE + 32'h10, 32'hdead_beef, 4'h0, "mem_strb_0", t_acc, t_resp);
		for (int i = 0; i < TEST_WORDS; i++) begin
			run_op(1'b0, soc_pkg::MEM_BASE + 32'(i * 4), '0, '0,
				$sformatf("mem_read_%0d", i), t_acc, t_resp);
		end

		run_op(1'b1, soc_pkg::UART_BASE, 32'h0000_00a5, 4'h1, "uart_single", t_acc, t_resp);

		// second response must wait for the first frame
		run_op(1'b1, soc_pkg::UART_BASE, 32'h0000_003c, 4'h1, "uart_b2b_0", t_first, t_resp);
		run_op(1'b1, soc_pkg::UART_BASE + 32'd4, 32'h0000_00c3, 4'h1, "uart_b2b_1", t_acc, t_resp);
		if (t_resp - t_first >= 10 * soc_pkg::BAUD_DIV * 4) begin
			pass_cnt++;
			$display("Pass uart_b2b_timing");
		end else begin
			fail_cnt++;
			$display("second uart response arrived before the first frame finished");
		end

		run_op(1'b0, soc_pkg::UART_BASE, '0, '0, "uart_read", t_acc, t_resp);
		run_op(1'b0, bad_addr[0], '0, '0, "unmapped_read_0", t_acc, t_resp);
		run_op(1'b0, bad_addr[1], '0, '0, "unmapped_read_1", t_acc, t_resp);
		run_op(1'b1, bad_addr[1], 32'hffff_ffff, 4'hf, "unmapped_write_1", t_acc, t_resp);
		run_op(1'b1, bad_addr[3], 32'hffff_ffff, 4'hf, "unmapped_write_3", t_acc, t_resp);
		run_op(1'b0, soc_pkg::MEM_BASE, '0, '0, "mem_after_unmapped", t_acc, t_resp);

		// back-pressure, delays drawn inside the drive tasks
		for (int i = 0; i < 4; i++) begin
			addr = soc_pkg::MEM_BASE + 32'(i * 8);
			run_op(1'b1, addr, $random(seed), 4'hf, $sformatf("bp_write_%0d", i), t_acc, t_resp);
			run_op(1'b0, addr, '0, '0, $sformatf("bp_read_%0d", i), t_acc, t_resp);
		end

		for (int i = 0; i < 40; i++) begin
			kind = $unsigned($random(seed)) % 3;
			if (kind == 0) begin
				addr = soc_pkg::MEM_BASE + 32'(($unsigned($random(seed)) % TEST_WORDS) * 4);
			end else if (kind == 1) begin
				addr = soc_pkg::UART_BASE + 32'($unsigned($random(seed)) % 8);
			end else begin
				addr = bad_addr[$unsigned($random(seed)) % 5];
			end
			run_op(1'($unsigned($random(seed)) % 2), addr, $random(seed), 4'($random(seed)),
				$sformatf("mix_%0d", i), t_acc, t_resp);
		end

		while (byte_exp_q.size() != 0 || word_exp_q.size() != 0 || resp_exp_q.size() != 0) begin
			@(negedge clk);
		end
		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
rtl/bus_pkg.sv
rtl/soc_pkg.sv
rtl/lite_if.sv
rtl/bus_xbar.sv
rtl/mem_slave.sv
rtl/uart_tx_slave.sv
rtl/lite_soc.sv
test/clk_gen.sv
test/soc_chk.sv
test/soc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_tb -f vlog.f -o soc_sim

out=$(./obj_dir/soc_sim)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "test passed"
